/* hdl/ntm_pkg.sv */
// Shared sizes, Q8.8 types and FSM encodings; imported by every RTL block of the controller
`default_nettype none

package ntm_pkg;

  //////////////////////////////////////////////////
  // Problem sizes
  //////////////////////////////////////////////////

  // External inputs x
  localparam int x_size = 4;
  // Read words r, flattened over heads
  localparam int r_size = 4;
  // Hidden rows h
  localparam int l_size = 4;
  // Operand vector z = [x; r; h_prev]
  localparam int z_size = x_size + r_size + l_size;
  // Combined [W K U] matrix, row major
  localparam int w_count = l_size * z_size;

  //////////////////////////////////////////////////
  // Fixed point
  //////////////////////////////////////////////////

  localparam int frac_bits = 8;

  // Q8.8 data word
  typedef logic signed [15:0] data_t;
  // Q24.16 accumulator, room for 12 full products
  typedef logic signed [39:0] acc_t;

  localparam data_t one_q  = 16'sd256;
  localparam data_t half_q = 16'sd128;

  // Addresses and indices
  typedef logic [5:0] waddr_t;
  typedef logic [3:0] zaddr_t;
  typedef logic [1:0] row_t;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Destination of a load strobe
  typedef enum logic [1:0] {
    ld_weight,
    ld_bias,
    ld_operand
  } load_target_e;

  // Step sequencer
  typedef enum logic [2:0] {
    st_idle,
    st_issue,
    st_drain,
    st_emit,
    st_commit
  } ctrl_state_e;

endpackage

`default_nettype wire

/* hdl/ntm_weight_store.sv */
// Weight and bias register file; loaded by strobes, read with one cycle latency by the step FSM
`timescale 1ns/1ps
`default_nettype none

module ntm_weight_store (
  input  logic            CLK,
  input  logic            RST,
  // Write side
  input  logic            wr_strobe,
  input  logic            wr_bias,
  input  ntm_pkg::waddr_t wr_addr,
  input  ntm_pkg::data_t  wr_data,
  // Read side
  input  ntm_pkg::waddr_t rd_addr,
  input  ntm_pkg::row_t   rd_row,
  output ntm_pkg::data_t  rd_weight,
  output ntm_pkg::data_t  rd_bias
);

  import ntm_pkg::*;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // Row l holds W(l,:), K(l,:), U(l,:) back to back
  data_t weights [w_count];
  data_t biases  [l_size];

  // Loads, whole file cleared on reset
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < w_count; i++) begin
        weights[i] <= '0;
      end
      for (int i = 0; i < l_size; i++) begin
        biases[i] <= '0;
      end
    end else if (wr_strobe) begin
      if (wr_bias) begin
        // Bias index in the low address bits
        biases[wr_addr[1:0]] <= wr_data;
      end else if (wr_addr < waddr_t'(w_count)) begin
        weights[wr_addr] <= wr_data;
      end
    end
  end

  //////////////////////////////////////////////////
  // Registered read
  //////////////////////////////////////////////////

  // Weight for the issued element
  always_ff @(posedge CLK) begin
    rd_weight <= weights[rd_addr];
  end

  // Bias of the issued row, same latency as the weight
  always_ff @(posedge CLK) begin
    rd_bias <= biases[rd_row];
  end

endmodule

`default_nettype wire

/* hdl/ntm_operand_buffer.sv */
// Operand vector z = [x; r; h_prev] with staging of the new hidden state; read by the step FSM
`timescale 1ns/1ps
`default_nettype none

module ntm_operand_buffer (
  input  logic            CLK,
  input  logic            RST,
  // Load of x and r
  input  logic            ld_strobe,
  input  ntm_pkg::zaddr_t ld_addr,
  input  ntm_pkg::data_t  ld_data,
  // Operand read
  input  ntm_pkg::zaddr_t z_index,
  output ntm_pkg::data_t  z_data,
  // New hidden state
  input  logic            stage_strobe,
  input  ntm_pkg::row_t   stage_row,
  input  ntm_pkg::data_t  stage_data,
  input  logic            commit_strobe
);

  import ntm_pkg::*;

  // x at 0..3, r at 4..7
  data_t xr     [x_size + r_size];
  // State seen by the current step
  data_t h_prev [l_size];
  // Rows produced by the current step
  data_t h_next [l_size];

  //////////////////////////////////////////////////
  // Loads and commit
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < x_size + r_size; i++) begin
        xr[i] <= '0;
      end
      for (int i = 0; i < l_size; i++) begin
        h_prev[i] <= '0;
      end
    end else begin
      if (ld_strobe && ld_addr < zaddr_t'(x_size + r_size)) begin
        xr[ld_addr[2:0]] <= ld_data;
      end
      // Last row may be staged in the commit cycle itself
      if (commit_strobe) begin
        for (int i = 0; i < l_size; i++) begin
          h_prev[i] <= (stage_strobe && stage_row == row_t'(i)) ? stage_data : h_next[i];
        end
      end
    end
  end

  // Staging keeps h_prev stable for all rows of a step
  always_ff @(posedge CLK) begin
    if (stage_strobe) begin
      h_next[stage_row] <= stage_data;
    end
  end

  //////////////////////////////////////////////////
  // Registered read
  //////////////////////////////////////////////////

  // Upper indices 8..11 map onto h_prev
  always_ff @(posedge CLK) begin
    if (z_index < zaddr_t'(x_size + r_size)) begin
      z_data <= xr[z_index[2:0]];
    end else begin
      z_data <= h_prev[z_index[1:0]];
    end
  end

endmodule

`default_nettype wire

/* hdl/ntm_mac_unit.sv */
// Two-stage multiply-accumulate for one row dot product; bias preload on first, Q8.8 sum on last
`timescale 1ns/1ps
`default_nettype none

module ntm_mac_unit (
  input  logic           CLK,
  input  logic           RST,
  input  logic           in_valid,
  input  logic           in_first,
  input  logic           in_last,
  input  ntm_pkg::data_t weight,
  input  ntm_pkg::data_t operand,
  input  ntm_pkg::data_t bias,
  output logic           sum_valid,
  output ntm_pkg::data_t sum
);

  import ntm_pkg::*;

  // Stage 1 registers, Q16.16 product
  logic signed [2*$bits(data_t)-1:0] prod_q;
  data_t bias_q;
  logic  p_valid;
  logic  p_first;
  logic  p_last;

  // Stage 2
  acc_t acc;
  acc_t acc_base;
  acc_t acc_next;
  acc_t acc_q8;
  // Bits that must agree with the sign for an in-range result
  logic [$bits(acc_t)-$bits(data_t):0] ovf_bits;

  //////////////////////////////////////////////////
  // Stage 1 multiply
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      p_valid <= 1'b0;
      p_first <= 1'b0;
      p_last  <= 1'b0;
    end else begin
      p_valid <= in_valid;
      p_first <= in_valid && in_first;
      p_last  <= in_valid && in_last;
    end
  end

  always_ff @(posedge CLK) begin
    prod_q <= weight * operand;
    bias_q <= bias;
  end

  //////////////////////////////////////////////////
  // Stage 2 accumulate
  //////////////////////////////////////////////////

  always_comb begin
    // Bias moved to Q24.16 starts a new row
    acc_base = p_first ? (acc_t'(bias_q) <<< frac_bits) : acc;
    acc_next = acc_base + acc_t'(prod_q);
    // Back to Q.8, floor rounding
    acc_q8   = acc_next >>> frac_bits;
    ovf_bits = acc_q8[$bits(acc_t)-1:$bits(data_t)-1];
  end

  always_ff @(posedge CLK) begin
    if (p_valid) begin
      acc <= acc_next;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum_valid <= 1'b0;
      sum       <= '0;
    end else begin
      sum_valid <= p_last;
      if (p_last) begin
        if (&ovf_bits || ~|ovf_bits) begin
          sum <= data_t'(acc_q8);
        end else begin
          // Clip to the Q8.8 limits
          sum <= acc_q8[$bits(acc_t)-1] ? 16'sh8000 : 16'sh7fff;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ntm_logistic.sv */
// Registered hard sigmoid 0.5 + v/4 clipped to [0, 1]; turns each row sum into its h value
`timescale 1ns/1ps
`default_nettype none

module ntm_logistic (
  input  logic           CLK,
  input  logic           RST,
  input  logic           in_valid,
  input  ntm_pkg::data_t in_data,
  output logic           out_valid,
  output ntm_pkg::data_t out_data
);

  import ntm_pkg::*;

  // One extra bit so the offset cannot wrap
  logic signed [$bits(data_t):0] scaled;

  //////////////////////////////////////////////////
  // Linear segment
  //////////////////////////////////////////////////

  // Slope 1/4 by arithmetic shift
  always_comb begin
    scaled = (in_data >>> 2) + half_q;
  end

  //////////////////////////////////////////////////
  // Clamp and register
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= in_valid;
      // Hold the last value between rows
      if (in_valid) begin
        if (scaled < 0) begin
          out_data <= '0;
        end else if (scaled > one_q) begin
          out_data <= one_q;
        end else begin
          out_data <= data_t'(scaled);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ntm_controller.sv */
// Top level of the NTM controller step; load port, step FSM and the row datapath instances
`timescale 1ns/1ps
`default_nettype none

module ntm_controller (
  input  logic                  CLK,
  input  logic                  RST,
  // Load port
  input  logic                  load_strobe,
  input  ntm_pkg::load_target_e load_target,
  input  ntm_pkg::waddr_t       load_addr,
  input  ntm_pkg::data_t        load_data,
  // Step port
  input  logic                  start,
  output logic                  busy,
  output logic                  h_valid,
  output ntm_pkg::row_t         h_index,
  output ntm_pkg::data_t        h_out,
  output logic                  done
);

  import ntm_pkg::*;

  ctrl_state_e state;
  row_t        row_cnt;
  zaddr_t      elem_cnt;

  // Issue side
  waddr_t rd_addr;
  logic   iss_valid;
  logic   iss_first;
  logic   iss_last;
  // Issue flags lined up with the read latency
  logic   mac_valid;
  logic   mac_first;
  logic   mac_last;

  // Storage side
  logic   ld_ok;
  logic   ws_wr_strobe;
  logic   ob_ld_strobe;
  data_t  rd_weight;
  data_t  rd_bias;
  data_t  z_data;
  logic   commit_strobe;

  // Datapath
  logic   sum_valid;
  data_t  sum;

  // Row numbers of rows still in the pipeline
  row_t   row_fifo [2];
  logic   fifo_wr;
  logic   fifo_rd;

  //////////////////////////////////////////////////
  // Load decode
  //////////////////////////////////////////////////

  // Loads only between steps
  assign ld_ok = load_strobe && (state == st_idle);

  // Out-of-range addresses dropped here
  assign ws_wr_strobe = ld_ok &&
    ((load_target == ld_weight && load_addr < waddr_t'(w_count)) ||
     (load_target == ld_bias && load_addr < waddr_t'(l_size)));
  assign ob_ld_strobe = ld_ok && load_target == ld_operand &&
    load_addr < waddr_t'(x_size + r_size);

  //////////////////////////////////////////////////
  // Step FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= st_idle;
      row_cnt  <= '0;
      elem_cnt <= '0;
      done     <= 1'b0;
    end else begin
      // Done and commit land with the last h
      done <= (state == st_emit);
      case (state)
        st_idle: begin
          if (start) begin
            state    <= st_issue;
            row_cnt  <= '0;
            elem_cnt <= '0;
          end
        end
        st_issue: begin
          if (elem_cnt == zaddr_t'(z_size - 1)) begin
            // Next row issues right away, rows overlap
            elem_cnt <= '0;
            if (row_cnt == row_t'(l_size - 1)) begin
              state <= st_drain;
            end else begin
              row_cnt <= row_cnt + 1'b1;
            end
          end else begin
            elem_cnt <= elem_cnt + 1'b1;
          end
        end
        st_drain: begin
          // Two cycles while the last row leaves the MAC
          if (elem_cnt == zaddr_t'(1)) begin
            state <= st_emit;
          end else begin
            elem_cnt <= elem_cnt + 1'b1;
          end
        end
        st_emit: begin
          state <= st_commit;
        end
        st_commit: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  assign busy          = (state != st_idle);
  assign commit_strobe = done;

  // Element address within the combined matrix
  assign rd_addr   = waddr_t'(row_cnt * z_size + elem_cnt);
  assign iss_valid = (state == st_issue);
  assign iss_first = iss_valid && (elem_cnt == '0);
  assign iss_last  = iss_valid && (elem_cnt == zaddr_t'(z_size - 1));

  // Read registers add one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      mac_valid <= 1'b0;
      mac_first <= 1'b0;
      mac_last  <= 1'b0;
    end else begin
      mac_valid <= iss_valid;
      mac_first <= iss_first;
      mac_last  <= iss_last;
    end
  end

  //////////////////////////////////////////////////
  // Row index FIFO
  //////////////////////////////////////////////////

  // Push on a row's last issue, pop on its h
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_fifo[0] <= '0;
      row_fifo[1] <= '0;
      fifo_wr     <= 1'b0;
      fifo_rd     <= 1'b0;
    end else begin
      if (iss_last) begin
        row_fifo[fifo_wr] <= row_cnt;
        fifo_wr           <= ~fifo_wr;
      end
      if (h_valid) begin
        fifo_rd <= ~fifo_rd;
      end
    end
  end

  assign h_index = row_fifo[fifo_rd];

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  ntm_weight_store u_weight_store (
    .CLK       (CLK),
    .RST       (RST),
    .wr_strobe (ws_wr_strobe),
    .wr_bias   (load_target == ld_bias),
    .wr_addr   (load_addr),
    .wr_data   (load_data),
    .rd_addr   (rd_addr),
    .rd_row    (row_cnt),
    .rd_weight (rd_weight),
    .rd_bias   (rd_bias)
  );

  ntm_operand_buffer u_operand_buffer (
    .CLK           (CLK),
    .RST           (RST),
    .ld_strobe     (ob_ld_strobe),
    .ld_addr       (zaddr_t'(load_addr)),
    .ld_data       (load_data),
    .z_index       (elem_cnt),
    .z_data        (z_data),
    .stage_strobe  (h_valid),
    .stage_row     (h_index),
    .stage_data    (h_out),
    .commit_strobe (commit_strobe)
  );

  ntm_mac_unit u_mac_unit (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (mac_valid),
    .in_first  (mac_first),
    .in_last   (mac_last),
    .weight    (rd_weight),
    .operand   (z_data),
    .bias      (rd_bias),
    .sum_valid (sum_valid),
    .sum       (sum)
  );

  ntm_logistic u_logistic (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (sum_valid),
    .in_data   (sum),
    .out_valid (h_valid),
    .out_data  (h_out)
  );

endmodule

`default_nettype wire

/* testbench/ntm_controller_props.sv */
// Concurrent checks on the step output protocol; bound into every ntm_controller instance
`timescale 1ns/1ps
`default_nettype none

module ntm_controller_props (
  input logic           CLK,
  input logic           RST,
  input logic           busy,
  input logic           h_valid,
  input ntm_pkg::row_t  h_index,
  input ntm_pkg::data_t h_out,
  input logic           done
);

  import ntm_pkg::*;

  // Output strobes only inside a step
  strobes_in_step: assert property (@(posedge CLK) disable iff (RST)
    (h_valid || done) |-> busy)
    else $error("h_valid or done seen while not busy");

  // Hard sigmoid range
  h_in_range: assert property (@(posedge CLK) disable iff (RST)
    h_valid |-> (h_out >= 16'sd0 && h_out <= one_q))
    else $error("h_out outside the range 0 to 1.0");

  // Last row and done together
  done_with_last_row: assert property (@(posedge CLK) disable iff (RST)
    done == (h_valid && h_index == row_t'(l_size - 1)))
    else $error("done and the h of the last row are not aligned");

endmodule

bind ntm_controller ntm_controller_props u_props (.*);

`default_nettype wire

/* testbench/ntm_controller_tb.sv */
// Self-checking testbench for one NTM controller step; loads random data, runs steps, checks each h
`timescale 1ns/1ps
`default_nettype none

module ntm_controller_tb;

  import ntm_pkg::*;

  localparam int test_count      = 6;
  localparam int max_steps       = 3;
  localparam int step_limit      = 80;
  localparam int watchdog_cycles = test_count * max_steps * 80;

  logic         CLK;
  logic         RST;
  logic         load_strobe;
  load_target_e load_target;
  waddr_t       load_addr;
  data_t        load_data;
  logic         start;
  logic         busy;
  logic         h_valid;
  row_t         h_index;
  data_t        h_out;
  logic         done;

  // Reference model state as plain integers
  int m_w  [w_count];
  int m_b  [l_size];
  int m_xr [x_size + r_size];
  int m_h  [l_size];
  int exp_h [l_size];

  bit [31:0] rng_state = 32'h8c13;
  int errors;
  int checks;

  ntm_controller uut (.*);

  // 20 ns clock
  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Random numbers and model
  //////////////////////////////////////////////////

  function automatic bit [31:0] xorshift32(input bit [31:0] s);
    bit [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Uniform value in lo..hi
  function automatic int rand_range(input int lo, input int hi);
    rng_state = xorshift32(rng_state);
    return lo + int'(rng_state % 32'(hi - lo + 1));
  endfunction

  function automatic int clamp(input longint v, input longint lo, input longint hi);
    if (v < lo) begin
      return int'(lo);
    end
    if (v > hi) begin
      return int'(hi);
    end
    return int'(v);
  endfunction

  task automatic clear_model();
    foreach (m_w[i]) m_w[i] = 0;
    foreach (m_b[i]) m_b[i] = 0;
    foreach (m_xr[i]) m_xr[i] = 0;
    foreach (m_h[i]) m_h[i] = 0;
  endtask

  // h = clip(0.5 + s/4) with s the saturated Q8.8 row sum
  task automatic predict_step();
    longint acc;
    int     s;
    int     z;
    for (int l = 0; l < l_size; l++) begin
      // Bias in Q16.16 plus exact products
      acc = longint'(m_b[l]) * 256;
      for (int e = 0; e < z_size; e++) begin
        z = (e < x_size + r_size) ? m_xr[e] : m_h[e - x_size - r_size];
        acc += longint'(m_w[l * z_size + e]) * longint'(z);
      end
      // Floor back to Q8.8
      s = clamp(acc >>> 8, -32768, 32767);
      exp_h[l] = clamp(longint'((s >>> 2) + 128), 0, 256);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  task automatic apply_reset(input int n);
    @(posedge CLK);
    #2;
    RST = 1'b1;
    repeat (n) @(posedge CLK);
    #2;
    RST = 1'b0;
    clear_model();
  endtask

  // One write per cycle with the strobe left high for back to back loads
  task automatic load_word(input load_target_e tgt, input int addr, input int data);
    @(posedge CLK);
    #2;
    load_strobe = 1'b1;
    load_target = tgt;
    load_addr   = waddr_t'(addr);
    load_data   = data_t'(data);
    // Out of range writes are dropped
    if (tgt == ld_weight && addr < w_count) begin
      m_w[addr] = data;
    end else if (tgt == ld_bias && addr < l_size) begin
      m_b[addr] = data;
    end else if (tgt == ld_operand && addr < x_size + r_size) begin
      m_xr[addr] = data;
    end
  endtask

  task automatic end_loads();
    @(posedge CLK);
    #2;
    load_strobe = 1'b0;
  endtask

  task automatic load_all(input int w_lo, input int w_hi, input int v_lo, input int v_hi,
                          input bit with_operands);
    for (int i = 0; i < w_count; i++) begin
      load_word(ld_weight, i, rand_range(w_lo, w_hi));
    end
    for (int i = 0; i < l_size; i++) begin
      load_word(ld_bias, i, rand_range(v_lo, v_hi));
    end
    if (with_operands) begin
      for (int i = 0; i < x_size + r_size; i++) begin
        load_word(ld_operand, i, rand_range(v_lo, v_hi));
      end
    end
    end_loads();
  endtask

  task automatic check_outputs_cleared();
    checks++;
    assert (!busy && !h_valid && !done) else begin
      $display("[ERROR] busy/h_valid/done: got %h/%h/%h expected 0/0/0", busy, h_valid, done);
      errors++;
    end
    assert (h_out == '0) else begin
      $display("[ERROR] h_out: got %h expected 0000", h_out);
      errors++;
    end
  endtask

  // Start pulse then a sample every cycle at the falling edge until busy drops
  task automatic run_step(input bit junk);
    int cycle;
    int n_valid;
    int n_done;
    bit seen_busy;
    bit finished;
    predict_step();
    cycle     = 0;
    n_valid   = 0;
    n_done    = 0;
    seen_busy = 1'b0;
    finished  = 1'b0;
    @(posedge CLK);
    #2;
    start = 1'b1;
    while (!finished && cycle < step_limit) begin
      @(posedge CLK);
      #2;
      // Stray starts and loads while busy
      if (junk && busy) begin
        start       = 1'(rand_range(0, 1));
        load_strobe = 1'b1;
        load_target = load_target_e'(rand_range(0, 2));
        load_addr   = waddr_t'(rand_range(0, 63));
        load_data   = data_t'(rand_range(-32768, 32767));
      end else begin
        start       = 1'b0;
        load_strobe = 1'b0;
      end
      @(negedge CLK);
      if (h_valid) begin
        checks++;
        if (n_valid < l_size) begin
          assert (int'(h_index) == n_valid) else begin
            $display("[ERROR] h_index: got %h expected %h", h_index, n_valid[1:0]);
            errors++;
          end
          assert (int'(h_out) == exp_h[n_valid]) else begin
            $display("[ERROR] h_out row %0d: got %h expected %h", n_valid, h_out,
                     data_t'(exp_h[n_valid]));
            errors++;
          end
          // Row l leaves the logistic 4 cycles after its last issue
          assert (cycle == z_size * (n_valid + 1) + 3) else begin
            $display("h_valid for row %0d came in cycle %0d instead of cycle %0d",
                     n_valid, cycle, z_size * (n_valid + 1) + 3);
            errors++;
          end
        end
        n_valid++;
      end
      if (done) begin
        n_done++;
        assert (h_valid && int'(h_index) == l_size - 1) else begin
          $display("done came without the h of the last row");
          errors++;
        end
      end
      if (busy) begin
        seen_busy = 1'b1;
      end else if (seen_busy) begin
        finished = 1'b1;
      end
      cycle++;
    end
    start       = 1'b0;
    load_strobe = 1'b0;
    assert (finished) else begin
      $display("step did not finish within %0d cycles", step_limit);
      errors++;
    end
    assert (n_valid == l_size && n_done == 1) else begin
      $display("step gave %0d h_valid pulses and %0d done pulses", n_valid, n_done);
      errors++;
    end
    // Committed state feeds the next step
    foreach (m_h[l]) m_h[l] = exp_h[l];
  endtask

  task automatic report_test(input string name, input int err_mark);
    $display("test %-28s %s, %0d errors", name, (errors == err_mark) ? "ok" : "FAILED",
             errors - err_mark);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int err_mark;
    RST         = 1'b1;
    load_strobe = 1'b0;
    load_target = ld_weight;
    load_addr   = '0;
    load_data   = '0;
    start       = 1'b0;
    errors      = 0;
    checks      = 0;
    apply_reset(8);

    // Cleared outputs and 0.5 everywhere from zero weights
    err_mark = errors;
    @(negedge CLK);
    check_outputs_cleared();
    run_step(1'b0);
    report_test("1 reset and zero weights", err_mark);

    err_mark = errors;
    load_all(-128, 127, -512, 511, 1'b1);
    run_step(1'b0);
    report_test("2 random small values", err_mark);

    // No reload between steps
    err_mark = errors;
    load_all(-128, 127, -512, 511, 1'b1);
    repeat (3) run_step(1'b0);
    report_test("3 recurrence", err_mark);

    // Positive then negative overflow of the row sum
    err_mark = errors;
    load_all(16384, 32767, 16384, 32767, 1'b1);
    run_step(1'b0);
    load_all(-32768, -16384, 16384, 32767, 1'b0);
    run_step(1'b0);
    report_test("4 saturation", err_mark);

    err_mark = errors;
    load_all(-128, 127, -512, 511, 1'b1);
    load_word(ld_weight, rand_range(w_count, 63), 16'sh7fff);
    load_word(ld_bias, rand_range(l_size, 63), 16'sh7fff);
    load_word(ld_operand, rand_range(x_size + r_size, 63), 16'sh7fff);
    end_loads();
    repeat (2) run_step(1'b1);
    report_test("5 ignored strobes", err_mark);

    err_mark = errors;
    load_all(-128, 127, -512, 511, 1'b1);
    @(posedge CLK);
    #2;
    start = 1'b1;
    @(posedge CLK);
    #2;
    start = 1'b0;
    repeat (20) @(posedge CLK);
    apply_reset(8);
    @(negedge CLK);
    check_outputs_cleared();
    // Only U and the operands reloaded so stale W, K, biases or h_prev show up
    for (int l = 0; l < l_size; l++) begin
      for (int e = x_size + r_size; e < z_size; e++) begin
        load_word(ld_weight, l * z_size + e, rand_range(-128, 127));
      end
    end
    for (int i = 0; i < x_size + r_size; i++) begin
      load_word(ld_operand, i, rand_range(-512, 511));
    end
    end_loads();
    run_step(1'b0);
    report_test("6 reset during a step", err_mark);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Run limit from the number of tests and steps
  initial begin
    repeat (watchdog_cycles) @(posedge CLK);
    $display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hdl/ntm_pkg.sv
hdl/ntm_weight_store.sv
hdl/ntm_operand_buffer.sv
hdl/ntm_mac_unit.sv
hdl/ntm_logistic.sv
hdl/ntm_controller.sv
testbench/ntm_controller_props.sv
testbench/ntm_controller_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := ntm_controller_tb
FILELIST := all.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST RESULT: PASS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
